// File: sim.f
src/fifo_pkg.sv
src/ram_if.sv
src/asym_fifo.sv
src/asym_converter.sv
src/dp_ram.sv
src/fifo_top.sv
sim/fifo_checker.sv
sim/fifo_tb.sv

// File: run.sh
#!/bin/sh
set -e

run_cfg() {
  w=$1
  r=$2
  dir=obj_dir_${w}_${r}
  verilator --binary --timing --assert --top-module fifo_tb \
    -GW_DATA_W=$w -GR_DATA_W=$r -Mdir $dir -f sim.f
  ./$dir/Vfifo_tb +verilator+error+limit+100
}

run_cfg 8 32
run_cfg 32 8

// File: sim/fifo_tb.sv
`timescale 1ns/100ps

module fifo_tb #(
  parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
);

  import fifo_pkg::*;

  localparam int RATIO    = fifo_ratio(W_DATA_W, R_DATA_W);
  localparam int NARROW_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
  localparam int WIDE_W   = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
  localparam int DEPTH    = 2 ** ADDR_W;
  localparam int W_INCR   = (W_DATA_W > R_DATA_W) ? RATIO : 1;
  localparam int R_INCR   = (R_DATA_W > W_DATA_W) ? RATIO : 1;

  // upper bound on the cycles the test sequence needs
  localparam int TEST_CYCLES    = 440 + 6 * DEPTH;
  localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

  typedef logic [W_DATA_W-1:0] w_word_t;
  typedef logic [R_DATA_W-1:0] r_word_t;
  typedef logic [NARROW_W-1:0] narrow_t;
  typedef logic [WIDE_W-1:0]   wide_t;

  logic        clk;
  logic        rst_n;
  logic        w_en;
  w_word_t     w_data;
  logic        r_en;
  logic        w_full;
  logic        r_empty;
  r_word_t     r_data;
  logic [ADDR_W:0] level;

  // reference model, one entry per narrow word
  narrow_t model_q[$];

  // expected state after the coming edge, and after the last edge
  logic    nxt_valid;
  int      nxt_level;
  logic    nxt_full;
  logic    nxt_empty;
  logic    nxt_rd_chk;
  r_word_t nxt_rdata;
  logic    cur_valid;
  int      cur_level;
  logic    cur_full;
  logic    cur_empty;
  logic    cur_rd_chk;
  r_word_t cur_rdata;

  int cycle_cnt;

  fifo_top #(
    .W_DATA_W (W_DATA_W),
    .R_DATA_W (R_DATA_W),
    .ADDR_W   (ADDR_W)
  ) i_dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .w_en_i    (w_en),
    .w_data_i  (w_data),
    .r_en_i    (r_en),
    .w_full_o  (w_full),
    .r_empty_o (r_empty),
    .r_data_o  (r_data),
    .level_o   (level)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // pops one read worth of narrow words, first word in the lowest lane
  function automatic r_word_t ref_read();
    wide_t word;
    int    count;
    word  = '0;
    count = (R_DATA_W > W_DATA_W) ? RATIO : 1;
    for (int i = 0; i < count; i++) begin
      word[i*NARROW_W +: NARROW_W] = model_q.pop_front();
    end
    return r_word_t'(word);
  endfunction

  function automatic void push_write(input w_word_t wd);
    wide_t word;
    int    count;
    word  = wide_t'(wd);
    count = (W_DATA_W > R_DATA_W) ? RATIO : 1;
    for (int i = 0; i < count; i++) begin
      model_q.push_back(word[i*NARROW_W +: NARROW_W]);
    end
  endfunction

  function automatic w_word_t rand_word();
    return w_word_t'($urandom);
  endfunction

  function automatic logic rand_bit();
    return 1'($urandom % 2);
  endfunction

  task automatic wait_drive_point();
    @(posedge clk);
    #1;
  endtask

  // drives one cycle of requests and predicts the state after the edge
  task automatic drive_cycle(input logic we, input w_word_t wd, input logic re);
    int   lvl;
    logic w_ok;
    logic r_ok;
    lvl  = model_q.size();
    w_ok = we && !(lvl > DEPTH - W_INCR);
    r_ok = re && !(lvl < R_INCR);
    w_en   = we;
    w_data = wd;
    r_en   = re;
    nxt_rd_chk = r_ok;
    if (r_ok) begin
      nxt_rdata = ref_read();
    end
    if (w_ok) begin
      push_write(wd);
    end
    lvl       = model_q.size();
    nxt_level = lvl;
    nxt_full  = lvl > DEPTH - W_INCR;
    nxt_empty = lvl < R_INCR;
    wait_drive_point();
    w_en       = 1'b0;
    r_en       = 1'b0;
    nxt_rd_chk = 1'b0;
  endtask

  task automatic apply_reset();
    rst_n  = 1'b0;
    w_en   = 1'b0;
    w_data = '0;
    r_en   = 1'b0;
    model_q.delete();
    nxt_valid  = 1'b1;
    nxt_level  = 0;
    nxt_full   = 1'b0;
    nxt_empty  = 1'b1;
    nxt_rd_chk = 1'b0;
    repeat (4) wait_drive_point();
    rst_n = 1'b1;
  endtask

  task automatic drain();
    while (!r_empty) begin
      drive_cycle(1'b0, '0, 1'b1);
    end
  endtask

  task automatic check_reset_state();
    check_value("r_empty_o", 64'(r_empty), 64'(1));
    check_value("w_full_o", 64'(w_full), 64'(0));
    check_value("level_o", 64'(level), 64'(0));
  endtask

  always @(posedge clk) begin
    cur_valid  <= nxt_valid;
    cur_level  <= nxt_level;
    cur_full   <= nxt_full;
    cur_empty  <= nxt_empty;
    cur_rd_chk <= nxt_rd_chk;
    cur_rdata  <= nxt_rdata;
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (cur_valid) begin
      check_value("level_o", 64'(level), 64'(cur_level));
      check_value("w_full_o", 64'(w_full), 64'(cur_full));
      check_value("r_empty_o", 64'(r_empty), 64'(cur_empty));
      if (cur_rd_chk) begin
        check_value("r_data_o", 64'(r_data), 64'(cur_rdata));
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Finished with errors");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h360f_4d70));
    rst_n      = 1'b0;
    w_en       = 1'b0;
    w_data     = '0;
    r_en       = 1'b0;
    nxt_valid  = 1'b0;
    nxt_level  = 0;
    nxt_full   = 1'b0;
    nxt_empty  = 1'b1;
    nxt_rd_chk = 1'b0;
    nxt_rdata  = '0;
    apply_reset();

    // reset state, reads on empty are ignored
    check_reset_state();
    repeat (3) drive_cycle(1'b0, '0, 1'b1);

    // half fill then drain in order
    for (int i = 0; i < (DEPTH / 2) / W_INCR; i++) begin
      drive_cycle(1'b1, rand_word(), 1'b0);
    end
    drain();

    // fill to full, extra writes dropped
    while (!w_full) begin
      drive_cycle(1'b1, rand_word(), 1'b0);
    end
    check_value("level_o", 64'(level), 64'(DEPTH));
    repeat (4) drive_cycle(1'b1, rand_word(), 1'b0);
    drain();

    // partial wide word stays unreadable
    if (W_DATA_W < R_DATA_W) begin
      repeat (RATIO - 1) drive_cycle(1'b1, rand_word(), 1'b0);
      repeat (3) begin
        drive_cycle(1'b0, '0, 1'b1);
        check_value("r_empty_o", 64'(r_empty), 64'(1));
      end
      drive_cycle(1'b1, rand_word(), 1'b0);
      drain();
    end

    repeat (400) drive_cycle(rand_bit(), rand_word(), rand_bit());
    drain();

    // reset in the middle of traffic
    repeat (8) drive_cycle(1'b1, rand_word(), 1'b0);
    apply_reset();
    check_reset_state();
    repeat (8) drive_cycle(1'b1, rand_word(), 1'b0);
    drain();
    repeat (2) drive_cycle(1'b0, '0, 1'b0);

    if (i_dut.i_fifo.i_checker.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("concurrent assertions in asym_fifo failed %0d times",
               i_dut.i_fifo.i_checker.fail_cnt);
      $display("Finished with errors");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: sim/fifo_checker.sv
`timescale 1ns/100ps

module fifo_checker #(
  parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            w_full_i,
  input logic            r_empty_i,
  input logic [ADDR_W:0] level_i,
  input logic            w_acc_i,
  input logic            r_acc_i
);

  localparam int DEPTH  = 2 ** ADDR_W;
  localparam int W_INCR = (W_DATA_W > R_DATA_W) ? W_DATA_W / R_DATA_W : 1;
  localparam int R_INCR = (R_DATA_W > W_DATA_W) ? R_DATA_W / W_DATA_W : 1;

  // failures seen so far
  int fail_cnt = 0;

  a_flags_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(w_full_i && r_empty_i))
  else begin
    fail_cnt++;
    $error("full and empty set together");
  end

  a_level_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    int'(level_i) <= DEPTH)
  else begin
    fail_cnt++;
    $error("level above depth");
  end

  // an accepted write needs room for a whole write word
  a_no_wr_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_acc_i |-> int'(level_i) <= DEPTH - W_INCR)
  else begin
    fail_cnt++;
    $error("write accepted while full");
  end

  // an accepted read needs a whole read word stored
  a_no_rd_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_acc_i |-> int'(level_i) >= R_INCR)
  else begin
    fail_cnt++;
    $error("read accepted while empty");
  end

endmodule

bind asym_fifo fifo_checker #(
  .W_DATA_W (W_DATA_W),
  .R_DATA_W (R_DATA_W),
  .ADDR_W   (ADDR_W)
) i_checker (
  .clk_i     (clk_i),
  .rst_n_i   (rst_n_i),
  .w_full_i  (w_full_o),
  .r_empty_i (r_empty_o),
  .level_i   (level_o),
  .w_acc_i   (w_acc_o),
  .r_acc_i   (r_acc_o)
);

// File: src/fifo_top.sv
`timescale 1ns/100ps

module fifo_top #(
  parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  input  logic                r_en_i,
  output logic                w_full_o,
  output logic                r_empty_o,
  output logic [R_DATA_W-1:0] r_data_o,
  output logic [ADDR_W:0]     level_o
);

  import fifo_pkg::*;

  localparam int RATIO       = fifo_ratio(W_DATA_W, R_DATA_W);
  localparam int WIDE_W      = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
  localparam int WIDE_ADDR_W = fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W);
  localparam int W_ADDR_W    = (W_DATA_W > R_DATA_W) ? WIDE_ADDR_W : ADDR_W;
  localparam int R_ADDR_W    = (R_DATA_W > W_DATA_W) ? WIDE_ADDR_W : ADDR_W;

  typedef logic [W_DATA_W-1:0] w_data_t;

  logic                w_acc;
  logic                r_acc;
  logic [W_ADDR_W-1:0] w_addr;
  logic [R_ADDR_W-1:0] r_addr;
  w_data_t             w_data;

  ram_if #(
    .RATIO  (RATIO),
    .DATA_W (WIDE_W),
    .ADDR_W (WIDE_ADDR_W)
  ) ram ();

  asym_fifo #(
    .W_DATA_W (W_DATA_W),
    .R_DATA_W (R_DATA_W),
    .ADDR_W   (ADDR_W)
  ) i_fifo (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .w_en_i    (w_en_i),
    .w_data_i  (w_data_i),
    .r_en_i    (r_en_i),
    .w_full_o  (w_full_o),
    .r_empty_o (r_empty_o),
    .level_o   (level_o),
    .w_acc_o   (w_acc),
    .r_acc_o   (r_acc),
    .w_addr_o  (w_addr),
    .r_addr_o  (r_addr),
    .w_data_o  (w_data)
  );

  asym_converter #(
    .W_DATA_W (W_DATA_W),
    .R_DATA_W (R_DATA_W),
    .ADDR_W   (ADDR_W)
  ) i_conv (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .w_acc_i  (w_acc),
    .w_addr_i (w_addr),
    .w_data_i (w_data),
    .r_acc_i  (r_acc),
    .r_addr_i (r_addr),
    .r_data_o (r_data_o),
    .ram      (ram.ctrl)
  );

  dp_ram #(
    .RATIO  (RATIO),
    .DATA_W (WIDE_W),
    .ADDR_W (WIDE_ADDR_W)
  ) i_ram (
    .clk_i (clk_i),
    .ram   (ram.mem)
  );

endmodule

// File: src/dp_ram.sv
`timescale 1ns/100ps

module dp_ram #(
  parameter int RATIO  = 4,
  parameter int DATA_W = 32,
  parameter int ADDR_W = 4
) (
  input logic clk_i,
  ram_if.mem  ram
);

  localparam int LANE_W = DATA_W / RATIO;

  typedef logic [DATA_W-1:0] wide_t;

  wide_t mem_q [2**ADDR_W];

  // per-lane writes
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < RATIO; i++) begin
      if (ram.w_en[i]) begin
        mem_q[ram.w_addr][i*LANE_W +: LANE_W] <= ram.w_data[i*LANE_W +: LANE_W];
      end
    end
  end

  // read word held until the next read
  always_ff @(posedge clk_i) begin
    if (|ram.r_en) begin
      ram.r_data <= mem_q[ram.r_addr];
    end
  end

endmodule

// File: src/asym_converter.sv
`timescale 1ns/100ps

module asym_converter #(
  parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                w_acc_i,
  input  logic [(W_DATA_W > R_DATA_W ?
                 fifo_pkg::fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W) :
                 ADDR_W)-1:0] w_addr_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  input  logic                r_acc_i,
  input  logic [(R_DATA_W > W_DATA_W ?
                 fifo_pkg::fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W) :
                 ADDR_W)-1:0] r_addr_i,
  output logic [R_DATA_W-1:0] r_data_o,
  ram_if.ctrl                 ram
);

  import fifo_pkg::*;

  localparam int RATIO  = fifo_ratio(W_DATA_W, R_DATA_W);
  localparam int LANE_W = $clog2(RATIO);

  typedef logic [RATIO-1:0] lane_en_t;

  generate
    if (W_DATA_W < R_DATA_W) begin : g_narrow_wr
      // low pointer bits pick the lane, high bits the wide word
      assign ram.w_en   = w_acc_i ? lane_en_t'(1) << w_addr_i[LANE_W-1:0] : '0;
      assign ram.w_addr = w_addr_i[ADDR_W-1:LANE_W];
      assign ram.w_data = {RATIO{w_data_i}};
    end else begin : g_wide_wr
      assign ram.w_en   = {RATIO{w_acc_i}};
      assign ram.w_addr = w_addr_i;
      assign ram.w_data = w_data_i;
    end
  endgenerate

  generate
    if (R_DATA_W < W_DATA_W) begin : g_narrow_rd
      logic [LANE_W-1:0] r_lane_q;

      assign ram.r_en   = r_acc_i ? lane_en_t'(1) << r_addr_i[LANE_W-1:0] : '0;
      assign ram.r_addr = r_addr_i[ADDR_W-1:LANE_W];

      // lane index lines up with the registered RAM word
      always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
          r_lane_q <= '0;
        end else if (r_acc_i) begin
          r_lane_q <= r_addr_i[LANE_W-1:0];
        end
      end

      assign r_data_o = ram.r_data[r_lane_q*R_DATA_W +: R_DATA_W];
    end else begin : g_wide_rd
      assign ram.r_en   = {RATIO{r_acc_i}};
      assign ram.r_addr = r_addr_i;
      assign r_data_o   = ram.r_data;
    end
  endgenerate

endmodule

// File: src/asym_fifo.sv
`timescale 1ns/100ps

module asym_fifo #(
  parameter int W_DATA_W = fifo_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_pkg::DEF_ADDR_W
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  input  logic                r_en_i,
  output logic                w_full_o,
  output logic                r_empty_o,
  output logic [ADDR_W:0]     level_o,
  output logic                w_acc_o,
  output logic                r_acc_o,
  output logic [(W_DATA_W > R_DATA_W ?
                 fifo_pkg::fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W) :
                 ADDR_W)-1:0] w_addr_o,
  output logic [(R_DATA_W > W_DATA_W ?
                 fifo_pkg::fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W) :
                 ADDR_W)-1:0] r_addr_o,
  output logic [W_DATA_W-1:0] w_data_o
);

  import fifo_pkg::*;

  localparam int RATIO       = fifo_ratio(W_DATA_W, R_DATA_W);
  localparam int WIDE_ADDR_W = fifo_wide_addr_w(W_DATA_W, R_DATA_W, ADDR_W);
  localparam int W_ADDR_W    = (W_DATA_W > R_DATA_W) ? WIDE_ADDR_W : ADDR_W;
  localparam int R_ADDR_W    = (R_DATA_W > W_DATA_W) ? WIDE_ADDR_W : ADDR_W;

  typedef logic [ADDR_W:0]   level_t;
  typedef logic [W_ADDR_W-1:0] w_ptr_t;
  typedef logic [R_ADDR_W-1:0] r_ptr_t;

  // level steps in narrow words
  localparam level_t DEPTH  = level_t'(2 ** ADDR_W);
  localparam level_t W_INCR = (W_DATA_W > R_DATA_W) ? level_t'(RATIO) : level_t'(1);
  localparam level_t R_INCR = (R_DATA_W > W_DATA_W) ? level_t'(RATIO) : level_t'(1);

  logic   w_acc;
  logic   r_acc;
  w_ptr_t w_ptr_q;
  r_ptr_t r_ptr_q;
  level_t level_q;
  level_t level_nxt;
  logic   w_full_q;
  logic   r_empty_q;

  // requests only pass while the flags allow them
  assign w_acc = w_en_i & ~w_full_q;
  assign r_acc = r_en_i & ~r_empty_q;

  always_comb begin
    level_nxt = level_q;
    if (w_acc) begin
      level_nxt = level_nxt + W_INCR;
    end
    if (r_acc) begin
      level_nxt = level_nxt - R_INCR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      w_ptr_q   <= '0;
      r_ptr_q   <= '0;
      level_q   <= '0;
      w_full_q  <= 1'b0;
      r_empty_q <= 1'b1;
    end else begin
      if (w_acc) begin
        w_ptr_q <= w_ptr_q + w_ptr_t'(1);
      end
      if (r_acc) begin
        r_ptr_q <= r_ptr_q + r_ptr_t'(1);
      end
      level_q   <= level_nxt;
      // flags come from the next level, so they track level_q
      w_full_q  <= level_nxt > (DEPTH - W_INCR);
      r_empty_q <= level_nxt < R_INCR;
    end
  end

  assign w_full_o  = w_full_q;
  assign r_empty_o = r_empty_q;
  assign level_o   = level_q;
  assign w_acc_o   = w_acc;
  assign r_acc_o   = r_acc;
  assign w_addr_o  = w_ptr_q;
  assign r_addr_o  = r_ptr_q;
  assign w_data_o  = w_data_i;

endmodule

// File: src/ram_if.sv
`timescale 1ns/100ps

interface ram_if #(
  parameter int RATIO  = 4,
  parameter int DATA_W = 32,
  parameter int ADDR_W = 4
);

  // write port, one enable per lane
  logic [RATIO-1:0]  w_en;
  logic [ADDR_W-1:0] w_addr;
  logic [DATA_W-1:0] w_data;

  // read port
  logic [RATIO-1:0]  r_en;
  logic [ADDR_W-1:0] r_addr;
  logic [DATA_W-1:0] r_data;

  modport ctrl (
    output w_en, w_addr, w_data, r_en, r_addr,
    input  r_data
  );

  modport mem (
    input  w_en, w_addr, w_data, r_en, r_addr,
    output r_data
  );

endinterface

// File: src/fifo_pkg.sv
package fifo_pkg;

  // default port widths
  localparam int DEF_W_DATA_W = 8;
  localparam int DEF_R_DATA_W = 32;

  // depth exponent, counted in narrow words
  localparam int DEF_ADDR_W = 6;

  // wider width over narrower width
  function automatic int fifo_ratio(input int w_data_w, input int r_data_w);
    if (w_data_w > r_data_w) begin
      return w_data_w / r_data_w;
    end
    return r_data_w / w_data_w;
  endfunction

  // address width of the wide side, in wide words
  function automatic int fifo_wide_addr_w(
    input int w_data_w,
    input int r_data_w,
    input int addr_w
  );
    return addr_w - $clog2(fifo_ratio(w_data_w, r_data_w));
  endfunction

endpackage
